// ==== rtl/fe_macros.svh ====
// Width and fetch-stride defines for the fetch PC generator
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// Virtual address width of a fetch PC
`define FE_VADDR_W 39

// Width of one fetched instruction
`define FE_INSTR_W 32

// Privilege mode width (user, supervisor, machine)
`define FE_PRIV_W 2

// Byte step between sequential fetches
`define FE_FETCH_STRIDE 4

`endif

// ==== rtl/fe_pkg.sv ====
// Command, queue message and fetch controller types for the fetch PC generator
`include "fe_macros.svh"

package fe_pkg;

   // Frontend command opcodes
   typedef enum logic [2:0]
   {
      e_op_state_reset        = 3'd0,
      e_op_pc_redirection     = 3'd1,
      e_op_itlb_fill_response = 3'd2,
      e_op_icache_fence       = 3'd3,
      e_op_itlb_fence         = 3'd4
   } fe_opcode_e;

   // Subopcodes of a PC redirection
   typedef enum logic [1:0]
   {
      e_subop_redirect           = 2'd0,
      e_subop_trap               = 2'd1,
      e_subop_translation_switch = 2'd2
   } fe_subop_e;

   // Command word from the backend
   typedef struct packed
   {
      fe_opcode_e             opcode;
      fe_subop_e              subopcode;
      logic [`FE_VADDR_W-1:0] vaddr;
      logic [`FE_PRIV_W-1:0]  priv;
      logic                   translation_enabled;
   } fe_cmd_s;

   typedef enum logic
   {
      e_fe_fetch     = 1'b0,
      e_fe_exception = 1'b1
   } fe_msg_type_e;

   // Listed in decreasing priority
   typedef enum logic [1:0]
   {
      e_itlb_miss          = 2'd0,
      e_instr_page_fault   = 2'd1,
      e_instr_access_fault = 2'd2
   } fe_exc_code_e;

   typedef struct packed
   {
      logic [`FE_VADDR_W-1:0] pc;
      logic [`FE_INSTR_W-1:0] instr;
   } fe_fetch_s;

   // Padded out to the size of a fetch body
   typedef struct packed
   {
      logic [`FE_VADDR_W-1:0]                      vaddr;
      fe_exc_code_e                                exception_code;
      logic [`FE_INSTR_W-$bits(fe_exc_code_e)-1:0] padding;
   } fe_exception_s;

   // One message body, read as fetch or exception by msg_type
   typedef union packed
   {
      fe_fetch_s     fetch;
      fe_exception_s exception;
   } fe_msg_u;

   typedef struct packed
   {
      fe_msg_type_e msg_type;
      fe_msg_u      msg;
   } fe_queue_s;

   // Fetch controller states
   typedef enum logic [1:0]
   {
      e_wait  = 2'd0,
      e_stall = 2'd1,
      e_run   = 2'd2
   } fe_state_e;

endpackage

// ==== rtl/fe_if2_if.sv ====
// IF2 stage and its flush conditions, shared by the PC pipeline and queue packer
`include "fe_macros.svh"

interface fe_if2_if;

   // Fetch sitting in IF2 this cycle
   logic                   if2_v;
   logic [`FE_VADDR_W-1:0] if2_pc;

   // Outcome of the IF2 response
   logic                   flush;
   logic                   fetch_fail;
   logic                   exception_v;

   modport pipe
   (
      output if2_v,
      output if2_pc,
      input  flush,
      input  fetch_fail,
      input  exception_v
   );

   modport pack
   (
      input  if2_v,
      input  if2_pc,
      output flush,
      output fetch_fail,
      output exception_v
   );

endinterface

// ==== rtl/fe_cmd_unit.sv ====
// Frontend command decode with shadow privilege and translation-enable registers
`include "fe_macros.svh"

module fe_cmd_unit
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   fe_cmd_v_i,
   input  fe_pkg::fe_cmd_s        fe_cmd_i,
   output logic                   fe_cmd_yumi_o,
   output logic                   cmd_v_o,
   output logic [`FE_VADDR_W-1:0] cmd_vaddr_o,
   output logic [`FE_PRIV_W-1:0]  mem_priv_o,
   output logic                   mem_translation_en_o
);
   import fe_pkg::*;

   logic                  state_reset_v;
   logic                  pc_redirect_v;
   logic                  trap_v;
   logic                  translation_v;
   logic                  priv_w;
   logic                  translation_en_w;
   logic [`FE_PRIV_W-1:0] priv_r;
   logic                  translation_en_r;

   // Commands are taken the cycle they show up
   assign fe_cmd_yumi_o = fe_cmd_v_i;

   // Every command redirects the fetch stream
   assign cmd_v_o     = fe_cmd_v_i;
   assign cmd_vaddr_o = fe_cmd_i.vaddr;

   assign state_reset_v = fe_cmd_v_i & (fe_cmd_i.opcode == e_op_state_reset);
   assign pc_redirect_v = fe_cmd_v_i & (fe_cmd_i.opcode == e_op_pc_redirection);
   assign trap_v        = pc_redirect_v & (fe_cmd_i.subopcode == e_subop_trap);
   assign translation_v = pc_redirect_v & (fe_cmd_i.subopcode == e_subop_translation_switch);

   // Privilege changes on reset or trap, translation also on a switch
   assign priv_w           = state_reset_v | trap_v;
   assign translation_en_w = state_reset_v | trap_v | translation_v;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         priv_r           <= '0;
         translation_en_r <= 1'b0;
      end
      else
      begin
         if (priv_w)
            priv_r <= fe_cmd_i.priv;
         if (translation_en_w)
            translation_en_r <= fe_cmd_i.translation_enabled;
      end
   end

   // Bypass so the memory side sees the new mode with the redirect PC
   assign mem_priv_o           = priv_w ? fe_cmd_i.priv : priv_r;
   assign mem_translation_en_o = translation_en_w ? fe_cmd_i.translation_enabled
                                                  : translation_en_r;

endmodule

// ==== rtl/fe_pc_pipe.sv ====
// Fetch controller, resume PC, IF1/IF2 stage registers and next-PC selection
`include "fe_macros.svh"

module fe_pc_pipe
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   cmd_v_i,
   input  logic [`FE_VADDR_W-1:0] cmd_vaddr_i,
   input  logic                   next_pc_yumi_i,
   input  logic                   fe_queue_ready_i,
   fe_if2_if.pipe                 if2_o,
   output logic [`FE_VADDR_W-1:0] next_pc_o,
   output logic                   next_pc_v_o
);
   import fe_pkg::*;

   localparam logic [`FE_VADDR_W-1:0] fetch_stride = `FE_FETCH_STRIDE;

   fe_state_e              state_r;
   fe_state_e              state_n;
   logic                   is_wait;
   logic                   is_run;
   logic                   if2_kill;
   logic                   if1_v_n;
   logic                   if1_v_r;
   logic [`FE_VADDR_W-1:0] if1_pc_r;
   logic                   if2_v_r;
   logic [`FE_VADDR_W-1:0] if2_pc_r;
   logic [`FE_VADDR_W-1:0] pc_resume_r;

   assign is_wait = (state_r == e_wait);
   assign is_run  = (state_r == e_run);

   // IF2 is dropped on a flush and on any fetch that produced no message
   assign if2_kill = if2_o.flush | if2_o.fetch_fail;

   // Redirect first, then resume point while not running, else sequential
   always_comb
   begin
      if (cmd_v_i)
         next_pc_o = cmd_vaddr_i;
      else if (!is_run)
         next_pc_o = pc_resume_r;
      else
         next_pc_o = if1_pc_r + fetch_stride;
   end

   // A command must be fetchable right away even with the queue full
   assign next_pc_v_o = ~is_wait & (fe_queue_ready_i | cmd_v_i);

   // A sequential fetch taken while IF2 drops would skip ahead of the resume PC
   assign if1_v_n = next_pc_yumi_i & (cmd_v_i | ~if2_kill);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         // Idle until the backend sends a command
         e_wait:
            state_n = cmd_v_i ? e_stall : e_wait;
         // Retry the resume PC until a fetch is taken
         e_stall:
            state_n = if1_v_n ? e_run : e_stall;
         e_run:
         begin
            if (cmd_v_i)
               state_n = if1_v_n ? e_run : e_stall;
            else if (if2_o.fetch_fail)
               state_n = e_stall;
            else if (if2_o.exception_v)
               state_n = e_wait;
            else
               state_n = e_run;
         end
         default:
            state_n = e_wait;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= e_wait;
         if1_v_r <= 1'b0;
         if2_v_r <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         if1_v_r <= if1_v_n;
         if2_v_r <= if1_v_r & ~if2_kill;
      end
   end

   always_ff @(posedge clk_i)
   begin
      // IF1 keeps the last accepted PC so the sequential PC never skips
      if (next_pc_yumi_i)
         if1_pc_r <= next_pc_o;
      if2_pc_r <= if1_pc_r;
      // Tracks IF2 so a dropped fetch restarts at its own PC
      if (cmd_v_i)
         pc_resume_r <= cmd_vaddr_i;
      else if (is_run)
         pc_resume_r <= if2_pc_r;
   end

   assign if2_o.if2_v  = if2_v_r;
   assign if2_o.if2_pc = if2_pc_r;

endmodule

// ==== rtl/fe_queue_pack.sv ====
// Flush and exception conditions of IF2 and frontend queue message assembly
`include "fe_macros.svh"

module fe_queue_pack
(
   input  logic                   cmd_v_i,
   input  logic                   mem_resp_v_i,
   input  logic [`FE_INSTR_W-1:0] mem_resp_data_i,
   input  logic                   mem_resp_icache_miss_i,
   input  logic                   mem_resp_itlb_miss_i,
   input  logic                   mem_resp_page_fault_i,
   input  logic                   mem_resp_access_fault_i,
   input  logic                   fe_queue_ready_i,
   fe_if2_if.pack                 if2_i,
   output fe_pkg::fe_queue_s      fe_queue_o,
   output logic                   fe_queue_v_o,
   output logic                   mem_poison_o
);
   import fe_pkg::*;

   logic resp_v;
   logic itlb_miss;
   logic page_fault;
   logic access_fault;
   logic icache_miss;
   logic queue_miss;
   logic exception_v;
   logic flush;
   logic instr_v;

   // Response flags only count against a live IF2 fetch
   assign resp_v       = if2_i.if2_v & mem_resp_v_i;
   assign itlb_miss    = resp_v & mem_resp_itlb_miss_i;
   assign page_fault   = resp_v & mem_resp_page_fault_i;
   assign access_fault = resp_v & mem_resp_access_fault_i;
   assign icache_miss  = resp_v & mem_resp_icache_miss_i;
   assign queue_miss   = if2_i.if2_v & ~fe_queue_ready_i;

   // A redirect in the same cycle supersedes the faulting fetch
   assign exception_v = ~cmd_v_i & (itlb_miss | page_fault | access_fault);

   assign flush   = exception_v | icache_miss | queue_miss | cmd_v_i;
   assign instr_v = resp_v & ~flush;

   assign fe_queue_v_o = fe_queue_ready_i & (instr_v | exception_v);
   assign mem_poison_o = flush;

   assign if2_i.flush       = flush;
   assign if2_i.fetch_fail  = if2_i.if2_v & ~fe_queue_v_o;
   assign if2_i.exception_v = exception_v;

   always_comb
   begin
      // Unused body bits stay zero
      fe_queue_o = '0;
      if (exception_v)
      begin
         fe_queue_o.msg_type            = e_fe_exception;
         fe_queue_o.msg.exception.vaddr = if2_i.if2_pc;
         if (itlb_miss)
            fe_queue_o.msg.exception.exception_code = e_itlb_miss;
         else if (page_fault)
            fe_queue_o.msg.exception.exception_code = e_instr_page_fault;
         else
            fe_queue_o.msg.exception.exception_code = e_instr_access_fault;
      end
      else
      begin
         fe_queue_o.msg_type        = e_fe_fetch;
         fe_queue_o.msg.fetch.pc    = if2_i.if2_pc;
         fe_queue_o.msg.fetch.instr = mem_resp_data_i;
      end
   end

endmodule

// ==== rtl/fe_pc_gen.sv ====
// Fetch PC generator top level joining command decode, PC pipeline and queue packer
`include "fe_macros.svh"

module fe_pc_gen
(
   input  logic                   clk_i,
   input  logic                   reset_i,

   // Backend command
   input  logic                   fe_cmd_v_i,
   input  fe_pkg::fe_cmd_s        fe_cmd_i,
   output logic                   fe_cmd_yumi_o,

   // Fetch request to the icache and ITLB
   output logic [`FE_VADDR_W-1:0] next_pc_o,
   output logic                   next_pc_v_o,
   input  logic                   next_pc_yumi_i,

   output logic [`FE_PRIV_W-1:0]  mem_priv_o,
   output logic                   mem_translation_en_o,
   output logic                   mem_poison_o,

   // Response for the fetch in IF2
   input  logic                   mem_resp_v_i,
   input  logic [`FE_INSTR_W-1:0] mem_resp_data_i,
   input  logic                   mem_resp_icache_miss_i,
   input  logic                   mem_resp_itlb_miss_i,
   input  logic                   mem_resp_page_fault_i,
   input  logic                   mem_resp_access_fault_i,

   // Frontend queue
   output fe_pkg::fe_queue_s      fe_queue_o,
   output logic                   fe_queue_v_o,
   input  logic                   fe_queue_ready_i
);

   logic                   cmd_v;
   logic [`FE_VADDR_W-1:0] cmd_vaddr;

   fe_if2_if if2 ();

   fe_cmd_unit cmd0
   (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .fe_cmd_v_i           (fe_cmd_v_i),
      .fe_cmd_i             (fe_cmd_i),
      .fe_cmd_yumi_o        (fe_cmd_yumi_o),
      .cmd_v_o              (cmd_v),
      .cmd_vaddr_o          (cmd_vaddr),
      .mem_priv_o           (mem_priv_o),
      .mem_translation_en_o (mem_translation_en_o)
   );

   fe_pc_pipe pipe0
   (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .cmd_v_i          (cmd_v),
      .cmd_vaddr_i      (cmd_vaddr),
      .next_pc_yumi_i   (next_pc_yumi_i),
      .fe_queue_ready_i (fe_queue_ready_i),
      .if2_o            (if2.pipe),
      .next_pc_o        (next_pc_o),
      .next_pc_v_o      (next_pc_v_o)
   );

   fe_queue_pack pack0
   (
      .cmd_v_i                 (cmd_v),
      .mem_resp_v_i            (mem_resp_v_i),
      .mem_resp_data_i         (mem_resp_data_i),
      .mem_resp_icache_miss_i  (mem_resp_icache_miss_i),
      .mem_resp_itlb_miss_i    (mem_resp_itlb_miss_i),
      .mem_resp_page_fault_i   (mem_resp_page_fault_i),
      .mem_resp_access_fault_i (mem_resp_access_fault_i),
      .fe_queue_ready_i        (fe_queue_ready_i),
      .if2_i                   (if2.pack),
      .fe_queue_o              (fe_queue_o),
      .fe_queue_v_o            (fe_queue_v_o),
      .mem_poison_o            (mem_poison_o)
   );

endmodule

// ==== sim/fe_pc_model.svh ====
// Reference model of the queued PC stream, IF stage occupancy and memory mode bits
`ifndef FE_PC_MODEL_SVH
`define FE_PC_MODEL_SVH

logic [`FE_VADDR_W-1:0] exp_pc;
logic                   waiting;
logic                   if1_v_m;
logic [`FE_VADDR_W-1:0] if1_pc_m;
logic                   if2_v_m;
logic [`FE_VADDR_W-1:0] if2_pc_m;
logic [`FE_PRIV_W-1:0]  priv_m;
logic                   tren_m;

// Instruction word the memory returns for a PC, mixes all address bits
function automatic logic [`FE_INSTR_W-1:0] instr_hash(input logic [`FE_VADDR_W-1:0] pc);
   return (pc[31:0] * 32'h9e3779b1) ^ {25'd0, pc[38:32]} ^ 32'h5a5a_0000;
endfunction

function automatic logic priv_written(input logic cmd_v, input fe_cmd_s cmd);
   return cmd_v & ((cmd.opcode == e_op_state_reset)
                   | ((cmd.opcode == e_op_pc_redirection) & (cmd.subopcode == e_subop_trap)));
endfunction

// Translation also changes on a translation switch
function automatic logic tren_written(input logic cmd_v, input fe_cmd_s cmd);
   return priv_written(cmd_v, cmd)
          | (cmd_v & (cmd.opcode == e_op_pc_redirection)
             & (cmd.subopcode == e_subop_translation_switch));
endfunction

task automatic clear_model();
   exp_pc   = '0;
   waiting  = 1'b1;
   if1_v_m  = 1'b0;
   if1_pc_m = '0;
   if2_v_m  = 1'b0;
   if2_pc_m = '0;
   priv_m   = '0;
   tren_m   = 1'b0;
endtask

// One clock of the model, from the driven inputs and the expected queue transfer
task automatic advance_model(input logic cmd_v, input fe_cmd_s cmd, input logic yumi,
                             input logic [`FE_VADDR_W-1:0] fetch_pc, input logic msg_v,
                             input logic exc_v);
   logic kill;
   // A command, an exception or an IF2 fetch without a message drops everything in flight
   kill = cmd_v | exc_v | (if2_v_m & ~msg_v);
   if (priv_written(cmd_v, cmd))
      priv_m = cmd.priv;
   if (tren_written(cmd_v, cmd))
      tren_m = cmd.translation_enabled;
   if (cmd_v)
   begin
      exp_pc  = cmd.vaddr;
      waiting = 1'b0;
   end
   else if (msg_v & exc_v)
      waiting = 1'b1;
   else if (msg_v)
      exp_pc = exp_pc + `FE_FETCH_STRIDE;
   if2_v_m  = if1_v_m & ~kill;
   if2_pc_m = if1_pc_m;
   // The fetch of a redirect target survives its own flush
   if1_v_m  = yumi & (cmd_v | ~kill);
   if (yumi)
      if1_pc_m = fetch_pc;
endtask

`endif

// ==== sim/tb_fe_pc_gen.sv ====
// Testbench for the fetch PC generator with random stimulus checked against a model
`include "fe_macros.svh"

module tb_fe_pc_gen;
   timeunit 1ns;
   timeprecision 100ps;
   import fe_pkg::*;

   localparam int          CLK_PERIOD      = 8;
   localparam int          RESET_CYCLES    = 16;
   localparam int          IDLE_CYCLES     = 8;
   localparam int          TEST_CYCLES     = 3000;
   localparam int          WATCHDOG_CYCLES = TEST_CYCLES + 1000;
   localparam logic [31:0] RNG_SEED        = 32'h24c5fbd5;

   logic                   clk_i;
   logic                   reset_i;
   logic                   fe_cmd_v_i;
   fe_cmd_s                fe_cmd_i;
   logic                   fe_cmd_yumi_o;
   logic [`FE_VADDR_W-1:0] next_pc_o;
   logic                   next_pc_v_o;
   logic                   next_pc_yumi_i;
   logic [`FE_PRIV_W-1:0]  mem_priv_o;
   logic                   mem_translation_en_o;
   logic                   mem_poison_o;
   logic                   mem_resp_v_i;
   logic [`FE_INSTR_W-1:0] mem_resp_data_i;
   logic                   mem_resp_icache_miss_i;
   logic                   mem_resp_itlb_miss_i;
   logic                   mem_resp_page_fault_i;
   logic                   mem_resp_access_fault_i;
   fe_queue_s              fe_queue_o;
   logic                   fe_queue_v_o;
   logic                   fe_queue_ready_i;
   int                     err_count;
   int                     fetch_count;
   int                     exc_count;

   `include "fe_pc_model.svh"

   fe_pc_gen dut0 (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial
   begin
      #((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
      $display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   task automatic abort_run();
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
         abort_run();
      end
   endtask

   task automatic check_pc(input string name, input logic [`FE_VADDR_W-1:0] got,
                           input logic [`FE_VADDR_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
         abort_run();
      end
   endtask

   task automatic check_priv(input string name, input logic [`FE_PRIV_W-1:0] got,
                             input logic [`FE_PRIV_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
         abort_run();
      end
   endtask

   task automatic check_queue(input string name, input fe_queue_s got, input fe_queue_s exp);
      if (got !== exp)
      begin
         $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
         abort_run();
      end
   endtask

   // Nothing may be offered or reported before the first command
   task automatic check_after_reset();
      repeat (IDLE_CYCLES)
      begin
         @(posedge clk_i);
         #1;
         fe_queue_ready_i = $urandom_range(1);
         mem_resp_v_i     = $urandom_range(1);
         #3;
         check_bit("next_pc_v_o", next_pc_v_o, 1'b0);
         check_bit("fe_queue_v_o", fe_queue_v_o, 1'b0);
         check_priv("mem_priv_o", mem_priv_o, '0);
         check_bit("mem_translation_en_o", mem_translation_en_o, 1'b0);
      end
   endtask

   task automatic run_cycle();
      fe_cmd_s   cmd;
      fe_queue_s exp_msg;
      logic      cmd_v;
      logic      resp_v;
      logic      exc_v;
      logic      fetch_v;
      logic      exp_qv;
      logic      poison;
      logic [2:0] faults;
      int        pick;
      @(posedge clk_i);
      #1;
      // Commands come often while waiting so the run keeps moving
      cmd_v                   = ($urandom_range(waiting ? 7 : 47) == 0);
      cmd.opcode              = fe_opcode_e'($urandom_range(4));
      cmd.subopcode           = fe_subop_e'($urandom_range(2));
      cmd.vaddr               = {7'($urandom_range(127)), $urandom()};
      cmd.vaddr[1:0]          = 2'b00;
      cmd.priv                = $urandom_range(3);
      cmd.translation_enabled = $urandom_range(1);
      fe_cmd_v_i              = cmd_v;
      fe_cmd_i                = cmd;
      fe_queue_ready_i        = ($urandom_range(7) != 0);
      mem_resp_v_i            = ($urandom_range(9) != 0);
      mem_resp_data_i         = instr_hash(if2_pc_m);
      pick                    = $urandom_range(99);
      faults                  = (pick < 4) ? 3'($urandom_range(7, 1)) : 3'b000;
      mem_resp_icache_miss_i  = (pick >= 4) && (pick < 7);
      mem_resp_itlb_miss_i    = faults[0];
      mem_resp_page_fault_i   = faults[1];
      mem_resp_access_fault_i = faults[2];
      #1;
      next_pc_yumi_i = next_pc_v_o & ($urandom_range(3) != 0);
      #2;
      resp_v  = if2_v_m & mem_resp_v_i;
      exc_v   = ~cmd_v & resp_v & (|faults);
      fetch_v = ~cmd_v & resp_v & ~(|faults) & ~mem_resp_icache_miss_i;
      exp_qv  = fe_queue_ready_i & (exc_v | fetch_v);
      poison  = cmd_v | exc_v | (resp_v & mem_resp_icache_miss_i)
                | (if2_v_m & ~fe_queue_ready_i);
      check_bit("fe_cmd_yumi_o", fe_cmd_yumi_o, cmd_v);
      if (cmd_v)
         check_pc("next_pc_o", next_pc_o, cmd.vaddr);
      check_bit("next_pc_v_o", next_pc_v_o, ~waiting & (fe_queue_ready_i | cmd_v));
      check_priv("mem_priv_o", mem_priv_o, priv_written(cmd_v, cmd) ? cmd.priv : priv_m);
      check_bit("mem_translation_en_o", mem_translation_en_o,
                tren_written(cmd_v, cmd) ? cmd.translation_enabled : tren_m);
      check_bit("mem_poison_o", mem_poison_o, poison);
      check_bit("fe_queue_v_o", fe_queue_v_o, exp_qv);
      if (exp_qv)
      begin
         exp_msg = '0;
         if (exc_v)
         begin
            exp_msg.msg_type                     = e_fe_exception;
            exp_msg.msg.exception.vaddr          = exp_pc;
            exp_msg.msg.exception.exception_code = faults[0] ? e_itlb_miss
                                                 : faults[1] ? e_instr_page_fault
                                                 : e_instr_access_fault;
            exc_count++;
         end
         else
         begin
            exp_msg.msg_type        = e_fe_fetch;
            exp_msg.msg.fetch.pc    = exp_pc;
            exp_msg.msg.fetch.instr = instr_hash(exp_pc);
            fetch_count++;
         end
         check_queue("fe_queue_o", fe_queue_o, exp_msg);
      end
      advance_model(cmd_v, cmd, next_pc_yumi_i, next_pc_o, exp_qv, exc_v);
   endtask

   initial
   begin
      void'($urandom(RNG_SEED));
      err_count               = 0;
      fetch_count             = 0;
      exc_count               = 0;
      reset_i                 = 1'b1;
      fe_cmd_v_i              = 1'b0;
      fe_cmd_i                = '0;
      next_pc_yumi_i          = 1'b0;
      mem_resp_v_i            = 1'b0;
      mem_resp_data_i         = '0;
      mem_resp_icache_miss_i  = 1'b0;
      mem_resp_itlb_miss_i    = 1'b0;
      mem_resp_page_fault_i   = 1'b0;
      mem_resp_access_fault_i = 1'b0;
      fe_queue_ready_i        = 1'b0;
      clear_model();
      repeat (RESET_CYCLES) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      check_after_reset();
      repeat (TEST_CYCLES) run_cycle();
      if (fetch_count == 0 || exc_count == 0)
      begin
         $display("Too few queue messages: %0d fetches and %0d exceptions",
                  fetch_count, exc_count);
         err_count++;
      end
      if (err_count == 0)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
         abort_run();
   end

endmodule

// ==== vlog.f ====
+incdir+rtl
+incdir+sim
rtl/fe_pkg.sv
rtl/fe_if2_if.sv
rtl/fe_cmd_unit.sv
rtl/fe_pc_pipe.sv
rtl/fe_queue_pack.sv
rtl/fe_pc_gen.sv
sim/tb_fe_pc_gen.sv

// ==== Bender.yml ====
package:
  name: fe_pc_gen

export_include_dirs:
  - rtl

sources:
  - rtl/fe_pkg.sv
  - rtl/fe_if2_if.sv
  - rtl/fe_cmd_unit.sv
  - rtl/fe_pc_pipe.sv
  - rtl/fe_queue_pack.sv
  - rtl/fe_pc_gen.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fe_pc_gen.sv
